// File: list.f
hw/wr_resp_bank_pkg.sv
hw/link_if.sv
hw/slot_allocator.sv
hw/link_table.sv
hw/queue_pointers.sv
hw/release_select.sv
hw/msg_ram.sv
hw/wr_resp_bank.sv
sim/tb_clk_gen.sv
sim/tb_wr_resp_bank.sv

// File: Bender.yml
package:
  name: wr_resp_bank

dependencies: {}

sources:
  # RTL in compile order
  - hw/wr_resp_bank_pkg.sv
  - hw/link_if.sv
  - hw/slot_allocator.sv
  - hw/link_table.sv
  - hw/queue_pointers.sv
  - hw/release_select.sv
  - hw/msg_ram.sv
  - hw/wr_resp_bank.sv
  # Testbench
  - target: simulation
    files:
      - sim/tb_clk_gen.sv
      - sim/tb_wr_resp_bank.sv

// File: sim/tb_wr_resp_bank.sv
// Table-driven testbench of the write-response bank with a reference model; top of the sim build
module tb_wr_resp_bank import wr_resp_bank_pkg::*; ();
  timeunit 1ns;
  timeprecision 1ps;

  typedef enum logic [1:0] {OpReserve, OpFill, OpEnable, OpDrain} op_e;

  typedef struct packed {
    logic [2:0] test;
    op_e        op;
    id_t        id;
    logic       ready;
    logic       flag;
  } row_t;

  localparam int NumRows = 45;
  localparam int NumTests = 6;
  localparam int ResetCycles = 10;

  ////////////////////////////////////////////////////////////////////////////
  // Stimulus table
  ////////////////////////////////////////////////////////////////////////////

  // Ready level is the handshake level, or all-on for an enable row
  // Flag is the expected o_rsv_valid, o_in_ready or release
  localparam row_t Rows [NumRows] = '{
    // test, operation, ID, ready level, expected flag
    '{1, OpReserve, 0, 0, 1}, '{1, OpDrain, 0, 1, 0},
    '{2, OpReserve, 0, 1, 1}, '{2, OpReserve, 1, 1, 1}, '{2, OpReserve, 2, 1, 1},
    '{2, OpReserve, 0, 1, 1}, '{2, OpReserve, 1, 1, 1}, '{2, OpReserve, 2, 1, 1},
    '{2, OpReserve, 0, 1, 1}, '{2, OpReserve, 1, 1, 1}, '{2, OpReserve, 2, 1, 1},
    '{2, OpReserve, 0, 1, 1}, '{2, OpReserve, 1, 1, 1}, '{2, OpReserve, 2, 1, 1},
    '{2, OpReserve, 0, 1, 1}, '{2, OpReserve, 1, 1, 1}, '{2, OpReserve, 2, 1, 1},
    '{2, OpReserve, 0, 1, 1}, '{2, OpReserve, 3, 1, 0},
    '{3, OpFill, 3, 0, 0}, '{3, OpFill, 1, 0, 1},
    '{4, OpEnable, 0, 1, 0}, '{4, OpFill, 2, 0, 1}, '{4, OpFill, 0, 0, 1},
    '{4, OpFill, 0, 0, 1}, '{4, OpDrain, 1, 1, 1}, '{4, OpReserve, 3, 1, 1},
    '{4, OpDrain, 0, 1, 1}, '{4, OpReserve, 3, 1, 1}, '{4, OpDrain, 0, 1, 1},
    '{4, OpDrain, 2, 1, 1}, '{4, OpReserve, 3, 1, 1}, '{4, OpReserve, 3, 1, 1},
    '{5, OpEnable, 0, 0, 0}, '{5, OpFill, 0, 0, 1}, '{5, OpFill, 1, 0, 1},
    '{5, OpDrain, 1, 1, 1}, '{5, OpDrain, 0, 1, 0}, '{5, OpReserve, 3, 1, 1},
    '{6, OpFill, 2, 0, 1}, '{6, OpFill, 3, 0, 1}, '{6, OpDrain, 2, 0, 1},
    '{6, OpEnable, 0, 1, 0}, '{6, OpDrain, 3, 0, 1}, '{6, OpDrain, 0, 1, 1}
  };

  string test_names [1:NumTests] = '{"reset state", "lowest free reservation",
    "input ready per ID", "in-order release", "release enable hold-back",
    "output back-pressure"};

  logic                clk;
  logic                rst_n;
  logic [NumIds-1:0]   i_rsv_id_onehot;
  logic                i_rsv_ready;
  logic                o_rsv_valid;
  addr_t               o_rsv_addr;
  logic                i_in_valid;
  id_t                 i_in_id;
  msg_t                i_in_msg;
  logic                o_in_ready;
  logic [Capacity-1:0] i_release_en;
  logic                i_out_ready;
  logic                o_out_valid;
  id_t                 o_out_id;
  msg_t                o_out_msg;
  logic [Capacity-1:0] o_released_onehot;

  // Reference model state
  logic [Capacity-1:0] occ;
  addr_t               rsv_q [NumIds][$];
  addr_t               done_slot_q [NumIds][$];
  msg_t                done_msg_q [NumIds][$];
  logic                stg_valid;
  id_t                 stg_id;
  addr_t               stg_addr;
  msg_t                stg_msg;

  logic [31:0] lfsr;
  int checks;
  int errors;
  int test_checks;
  int test_errors;
  int limit;
  int cycles = 0;

  tb_clk_gen clk_gen0 (.o_clk(clk), .o_rst_n(rst_n));

  wr_resp_bank dut0 (.clk_i(clk), .rst_ni(rst_n), .*);

  ////////////////////////////////////////////////////////////////////////////
  // Helpers
  ////////////////////////////////////////////////////////////////////////////

  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
  endfunction

  // One LFSR step per payload bit
  function automatic msg_t next_msg();
    msg_t m;
    m = '0;
    for (int b = 0; b < MsgWidth; b++) begin
      m = {m[MsgWidth-2:0], lfsr[0]};
      lfsr = lfsr_next(lfsr);
    end
    return m;
  endfunction

  function automatic addr_t lowest_free();
    for (int a = 0; a < Capacity; a++) begin
      if (!occ[a]) begin
        return addr_t'(a);
      end
    end
    return '0;
  endfunction

  function automatic int row_cycles(input op_e op);
    return (op == OpDrain) ? 8 : 2;
  endfunction

  task automatic check_eq(input string name, input logic [31:0] got, input logic [31:0] exp);
    checks++;
    assert (got === exp) else begin
      $display("Mismatch at %0t ns: %s is %0h, expected %0h", $time, name, got, exp);
      errors++;
    end
  endtask

  task automatic check_true(input logic cond, input string what);
    checks++;
    assert (cond) else begin
      $display("Error at %0t ns: %s", $time, what);
      errors++;
    end
  endtask

  // Lowest ID whose oldest filled slot is enabled enters the empty output stage
  task automatic model_select();
    for (int i = 0; i < NumIds; i++) begin
      if (!stg_valid && done_slot_q[i].size() != 0 && i_release_en[done_slot_q[i][0]]) begin
        stg_addr = done_slot_q[i].pop_front();
        stg_msg = done_msg_q[i].pop_front();
        stg_id = id_t'(i);
        stg_valid = 1'b1;
      end
    end
  endtask

  task automatic wait_out_valid();
    @(negedge clk);
    while (!o_out_valid) begin
      @(negedge clk);
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Row operations
  ////////////////////////////////////////////////////////////////////////////

  task automatic reserve(input id_t id, input logic ready, input logic flag);
    logic fire;
    i_rsv_id_onehot <= NumIds'(1) << id;
    i_rsv_ready <= ready;
    @(negedge clk);
    check_eq("o_rsv_valid", o_rsv_valid, flag);
    if (flag) begin
      check_eq("o_rsv_addr", o_rsv_addr, lowest_free());
    end
    fire = ready && !(&occ);
    @(posedge clk);
    i_rsv_ready <= 1'b0;
    i_rsv_id_onehot <= '0;
    if (fire) begin
      rsv_q[id].push_back(lowest_free());
      occ[lowest_free()] = 1'b1;
    end
    @(posedge clk);
  endtask

  task automatic fill(input id_t id, input logic flag);
    msg_t msg;
    msg = next_msg();
    i_in_valid <= 1'b1;
    i_in_id <= id;
    i_in_msg <= msg;
    @(negedge clk);
    check_eq("o_in_ready", o_in_ready, flag);
    @(posedge clk);
    i_in_valid <= 1'b0;
    if (rsv_q[id].size() != 0) begin
      done_slot_q[id].push_back(rsv_q[id].pop_front());
      done_msg_q[id].push_back(msg);
    end
    // Entry is selectable in the idle cycle that follows
    @(posedge clk);
    model_select();
  endtask

  // All slots on, or every slot held by one ID off
  task automatic set_enables(input id_t id, input logic all_on);
    logic [Capacity-1:0] en;
    en = '1;
    if (!all_on) begin
      for (int k = 0; k < rsv_q[id].size(); k++) begin
        en[rsv_q[id][k]] = 1'b0;
      end
      for (int k = 0; k < done_slot_q[id].size(); k++) begin
        en[done_slot_q[id][k]] = 1'b0;
      end
    end
    i_release_en <= en;
    @(posedge clk);
    @(posedge clk);
    model_select();
  endtask

  task automatic drain(input id_t id, input logic ready, input logic flag);
    id_t  held_id;
    msg_t held_msg;
    if (!flag) begin
      i_out_ready <= 1'b1;
      repeat (3) begin
        @(negedge clk);
        check_eq("o_out_valid", o_out_valid, 1'b0);
        check_eq("o_released_onehot", o_released_onehot, '0);
      end
    end else begin
      check_true(stg_valid && stg_id == id,
                 "the model's next response is not from the table's ID");
      if (!ready) begin
        wait_out_valid();
        held_id = o_out_id;
        held_msg = o_out_msg;
        repeat (3) begin
          @(negedge clk);
          check_eq("o_out_valid", o_out_valid, 1'b1);
          check_eq("o_out_id", o_out_id, held_id);
          check_eq("o_out_msg", o_out_msg, held_msg);
          check_eq("o_released_onehot", o_released_onehot, '0);
        end
        @(posedge clk);
      end
      i_out_ready <= 1'b1;
      wait_out_valid();
      check_eq("o_out_id", o_out_id, stg_id);
      check_eq("o_out_msg", o_out_msg, stg_msg);
      check_eq("o_released_onehot", o_released_onehot, 32'd1 << stg_addr);
      occ[stg_addr] = 1'b0;
      stg_valid = 1'b0;
    end
    @(posedge clk);
    i_out_ready <= 1'b0;
    model_select();
    @(posedge clk);
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Main sequence and timeout
  ////////////////////////////////////////////////////////////////////////////

  initial begin
    i_rsv_id_onehot = '0;
    i_rsv_ready = 1'b0;
    i_in_valid = 1'b0;
    i_in_id = '0;
    i_in_msg = '0;
    i_release_en = '0;
    i_out_ready = 1'b0;
    occ = '0;
    stg_valid = 1'b0;
    lfsr = 32'h22ce;
    checks = 0;
    errors = 0;
    limit = ResetCycles;
    for (int r = 0; r < NumRows; r++) begin
      limit += 2 * row_cycles(Rows[r].op);
    end

    wait (rst_n === 1'b1);
    @(posedge clk);
    for (int r = 0; r < NumRows; r++) begin
      if (r == 0 || Rows[r].test != Rows[r-1].test) begin
        test_checks = checks;
        test_errors = errors;
      end
      case (Rows[r].op)
        OpReserve: reserve(Rows[r].id, Rows[r].ready, Rows[r].flag);
        OpFill:    fill(Rows[r].id, Rows[r].flag);
        OpEnable:  set_enables(Rows[r].id, Rows[r].ready);
        default:   drain(Rows[r].id, Rows[r].ready, Rows[r].flag);
      endcase
      if (r == NumRows - 1 || Rows[r+1].test != Rows[r].test) begin
        $display("Test %0d (%s): %0d checks, %0d failed", Rows[r].test,
                 test_names[Rows[r].test], checks - test_checks, errors - test_errors);
      end
    end

    $display("Checks: %0d run, %0d failed", checks, errors);
    if (errors == 0) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  end

  always @(posedge clk) begin
    cycles++;
    if (cycles > limit) begin
      $display("Timeout: the run did not finish within %0d cycles", limit);
      $display("** FAIL **");
      $finish;
    end
  end

endmodule

// File: sim/tb_clk_gen.sv
// Testbench clock and reset source; 10 ns clock, active-low reset released after 10 cycles
module tb_clk_gen (
  output logic o_clk,
  output logic o_rst_n
);
  timeunit 1ns;
  timeprecision 1ps;

  initial begin
    o_clk = 1'b0;
    forever begin
      #5 o_clk = ~o_clk;
    end
  end

  // Reset leaves on a rising edge, like every other driven input
  initial begin
    o_rst_n = 1'b0;
    repeat (10) @(posedge o_clk);
    o_rst_n <= 1'b1;
  end

endmodule

// File: hw/wr_resp_bank.sv
// Write-response bank top level; reserve a slot per AXI ID, fill it, release responses in ID order
module wr_resp_bank import wr_resp_bank_pkg::*; (
  input  logic                clk_i,
  input  logic                rst_ni,

  // Reservation
  input  logic [NumIds-1:0]   i_rsv_id_onehot,
  input  logic                i_rsv_ready,
  output logic                o_rsv_valid,
  output addr_t               o_rsv_addr,

  // Response input
  input  logic                i_in_valid,
  input  id_t                 i_in_id,
  input  msg_t                i_in_msg,
  output logic                o_in_ready,

  // Multi-hot release enable, one bit per slot
  input  logic [Capacity-1:0] i_release_en,

  // Response output
  input  logic                i_out_ready,
  output logic                o_out_valid,
  output id_t                 o_out_id,
  output msg_t                o_out_msg,

  output logic [Capacity-1:0] o_released_onehot
);

  logic              rsv_fire;
  logic              fill_fire;
  addr_t             fill_addr;
  logic [NumIds-1:0] cand_valid;
  addr_t             cand_addr [NumIds];
  logic [NumIds-1:0] grant_onehot;
  logic              rd_en;
  addr_t             rd_addr;

  link_if link ();

  assign rsv_fire = o_rsv_valid && i_rsv_ready;
  assign fill_fire = i_in_valid && o_in_ready;

  ////////////////////////////////////////////////////////////////////////////
  // Slot bookkeeping
  ////////////////////////////////////////////////////////////////////////////

  slot_allocator u_slot_allocator (
    .clk_i            (clk_i),
    .rst_ni           (rst_ni),
    .i_rsv_fire       (rsv_fire),
    .i_release_onehot (o_released_onehot),
    .o_free_addr      (o_rsv_addr),
    .o_any_free       (o_rsv_valid)
  );

  link_table u_link_table (
    .clk_i  (clk_i),
    .rst_ni (rst_ni),
    .link   (link)
  );

  queue_pointers u_queue_pointers (
    .clk_i           (clk_i),
    .rst_ni          (rst_ni),
    .i_rsv_fire      (rsv_fire),
    .i_rsv_id_onehot (i_rsv_id_onehot),
    .i_free_addr     (o_rsv_addr),
    .i_fill_fire     (fill_fire),
    .i_fill_id       (i_in_id),
    .i_grant_onehot  (grant_onehot),
    .o_id_reserved   (o_in_ready),
    .o_fill_addr     (fill_addr),
    .o_cand_valid    (cand_valid),
    .o_cand_addr     (cand_addr),
    .link            (link)
  );

  ////////////////////////////////////////////////////////////////////////////
  // Release path and payload storage
  ////////////////////////////////////////////////////////////////////////////

  release_select u_release_select (
    .clk_i             (clk_i),
    .rst_ni            (rst_ni),
    .i_cand_valid      (cand_valid),
    .i_cand_addr       (cand_addr),
    .i_release_en      (i_release_en),
    .i_out_ready       (i_out_ready),
    .o_grant_onehot    (grant_onehot),
    .o_rd_en           (rd_en),
    .o_rd_addr         (rd_addr),
    .o_out_valid       (o_out_valid),
    .o_out_id          (o_out_id),
    .o_released_onehot (o_released_onehot)
  );

  // Message arrives one cycle after selection, with the output stage
  msg_ram #(
    .Width (MsgWidth),
    .Depth (Capacity)
  ) u_msg_ram (
    .clk_i     (clk_i),
    .i_wr_en   (fill_fire),
    .i_wr_addr (fill_addr),
    .i_wr_data (i_in_msg),
    .i_rd_en   (rd_en),
    .i_rd_addr (rd_addr),
    .o_rd_data (o_out_msg)
  );

endmodule

// File: hw/msg_ram.sv
// Two-port flop storage with synchronous write and registered read; any width and depth
module msg_ram #(
  parameter int unsigned Width = 8,
  parameter int unsigned Depth = 16
) (
  input  logic                     clk_i,
  input  logic                     i_wr_en,
  input  logic [$clog2(Depth)-1:0] i_wr_addr,
  input  logic [Width-1:0]         i_wr_data,
  input  logic                     i_rd_en,
  input  logic [$clog2(Depth)-1:0] i_rd_addr,
  output logic [Width-1:0]         o_rd_data
);

  logic [Width-1:0] mem [Depth];
  logic [Width-1:0] rd_data_q;

  always_ff @(posedge clk_i) begin
    if (i_wr_en) begin
      mem[i_wr_addr] <= i_wr_data;
    end
  end

  // Read data holds while no read is requested
  always_ff @(posedge clk_i) begin
    if (i_rd_en) begin
      rd_data_q <= mem[i_rd_addr];
    end
  end

  assign o_rd_data = rd_data_q;

endmodule

// File: hw/release_select.sv
// Release arbiter and output stage; lowest eligible identifier goes out, held under back-pressure
module release_select import wr_resp_bank_pkg::*; (
  input  logic                clk_i,
  input  logic                rst_ni,
  input  logic [NumIds-1:0]   i_cand_valid,
  input  addr_t               i_cand_addr [NumIds],
  input  logic [Capacity-1:0] i_release_en,
  input  logic                i_out_ready,
  output logic [NumIds-1:0]   o_grant_onehot,
  output logic                o_rd_en,
  output addr_t               o_rd_addr,
  output logic                o_out_valid,
  output id_t                 o_out_id,
  output logic [Capacity-1:0] o_released_onehot
);

  logic [NumIds-1:0] eligible;
  logic release_fire;
  logic stage_open;
  logic any_grant;
  id_t  grant_id;

  logic  out_valid_q;
  id_t   out_id_q;
  addr_t out_slot_q;

  ////////////////////////////////////////////////////////////////////////////
  // Selection
  ////////////////////////////////////////////////////////////////////////////

  for (genvar g = 0; g < NumIds; g++) begin : gen_eligible
    assign eligible[g] = i_cand_valid[g] && i_release_en[i_cand_addr[g]];
  end : gen_eligible

  assign release_fire = out_valid_q && i_out_ready;
  // Stage empty, or emptied by the handshake in this cycle
  assign stage_open = !out_valid_q || i_out_ready;

  always_comb begin
    o_grant_onehot = '0;
    grant_id = '0;
    for (int i = NumIds - 1; i >= 0; i--) begin
      if (eligible[i] && stage_open) begin
        o_grant_onehot = '0;
        o_grant_onehot[i] = 1'b1;
        grant_id = id_t'(i);
      end
    end
  end

  assign any_grant = |o_grant_onehot;
  assign o_rd_en = any_grant;
  assign o_rd_addr = i_cand_addr[grant_id];

  ////////////////////////////////////////////////////////////////////////////
  // Output stage
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      out_valid_q <= 1'b0;
    end else if (stage_open) begin
      out_valid_q <= any_grant;
    end
  end

  always_ff @(posedge clk_i) begin
    if (any_grant) begin
      out_id_q <= grant_id;
      out_slot_q <= o_rd_addr;
    end
  end

  assign o_out_valid = out_valid_q;
  assign o_out_id = out_id_q;

  // Slot is freed on the edge that ends the handshake
  for (genvar a = 0; a < Capacity; a++) begin : gen_released
    assign o_released_onehot[a] = release_fire && (out_slot_q == addr_t'(a));
  end : gen_released

endmodule

// File: hw/queue_pointers.sv
// Per-identifier linked-list queues; tracks head, fill and release pointers and their counts
module queue_pointers import wr_resp_bank_pkg::*; (
  input  logic              clk_i,
  input  logic              rst_ni,
  input  logic              i_rsv_fire,
  input  logic [NumIds-1:0] i_rsv_id_onehot,
  input  addr_t             i_free_addr,
  input  logic              i_fill_fire,
  input  id_t               i_fill_id,
  input  logic [NumIds-1:0] i_grant_onehot,
  output logic              o_id_reserved,
  output addr_t             o_fill_addr,
  output logic [NumIds-1:0] o_cand_valid,
  output addr_t             o_cand_addr [NumIds],
  link_if.queue             link
);

  // Head is the last reserved slot of a queue
  addr_t head_q [NumIds];
  addr_t head_d [NumIds];
  // Oldest reserved slot still waiting for its response
  addr_t fill_q [NumIds];
  addr_t fill_d [NumIds];
  // Oldest filled slot not yet handed to the output stage
  addr_t rel_q [NumIds];
  addr_t rel_d [NumIds];

  cnt_t rsv_cnt_q [NumIds];
  cnt_t rsv_cnt_d [NumIds];
  cnt_t filled_cnt_q [NumIds];
  cnt_t filled_cnt_d [NumIds];

  id_t grant_id;

  always_comb begin
    grant_id = '0;
    for (int i = 0; i < NumIds; i++) begin
      if (i_grant_onehot[i]) begin
        grant_id = id_t'(i);
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Link table access
  ////////////////////////////////////////////////////////////////////////////

  assign link.fill_addr = fill_q[i_fill_id];
  assign link.rel_addr = rel_q[grant_id];
  assign link.wr_next = i_free_addr;

  // Only a queue that still holds a slot needs the new slot chained behind its head
  always_comb begin
    link.wr_en = 1'b0;
    link.wr_addr = '0;
    for (int i = 0; i < NumIds; i++) begin
      if (i_rsv_fire && i_rsv_id_onehot[i] &&
          (rsv_cnt_q[i] != '0 || filled_cnt_q[i] != '0)) begin
        link.wr_en = 1'b1;
        link.wr_addr = head_q[i];
      end
    end
  end

  assign o_fill_addr = fill_q[i_fill_id];
  assign o_id_reserved = rsv_cnt_q[i_fill_id] != '0;

  ////////////////////////////////////////////////////////////////////////////
  // Pointer and count updates
  ////////////////////////////////////////////////////////////////////////////

  for (genvar g = 0; g < NumIds; g++) begin : gen_id
    logic rsv_hit;
    logic fill_hit;
    logic grant_hit;
    cnt_t filled_after_grant;

    assign rsv_hit = i_rsv_fire && i_rsv_id_onehot[g];
    assign fill_hit = i_fill_fire && (i_fill_id == id_t'(g));
    assign grant_hit = i_grant_onehot[g];
    assign filled_after_grant = filled_cnt_q[g] - cnt_t'(grant_hit);

    assign o_cand_valid[g] = filled_cnt_q[g] != '0;
    assign o_cand_addr[g] = rel_q[g];

    always_comb begin
      head_d[g] = head_q[g];
      fill_d[g] = fill_q[g];
      rel_d[g] = rel_q[g];
      rsv_cnt_d[g] = rsv_cnt_q[g] + cnt_t'(rsv_hit) - cnt_t'(fill_hit);
      filled_cnt_d[g] = filled_cnt_q[g] + cnt_t'(fill_hit) - cnt_t'(grant_hit);

      // Grant moves the release pointer at selection time
      if (grant_hit && filled_cnt_q[g] > cnt_t'(1)) begin
        rel_d[g] = link.rel_next;
      end

      if (fill_hit) begin
        if (rsv_cnt_q[g] > cnt_t'(1)) begin
          fill_d[g] = link.fill_next;
        end
        // Queue of filled entries empty, so the new entry is next to release
        if (filled_after_grant == '0) begin
          rel_d[g] = fill_q[g];
        end
      end

      if (rsv_hit) begin
        head_d[g] = i_free_addr;
        if (rsv_cnt_q[g] == '0 || (rsv_cnt_q[g] == cnt_t'(1) && fill_hit)) begin
          fill_d[g] = i_free_addr;
        end
      end
    end
  end : gen_id

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      for (int i = 0; i < NumIds; i++) begin
        head_q[i] <= '0;
        fill_q[i] <= '0;
        rel_q[i] <= '0;
        rsv_cnt_q[i] <= '0;
        filled_cnt_q[i] <= '0;
      end
    end else begin
      head_q <= head_d;
      fill_q <= fill_d;
      rel_q <= rel_d;
      rsv_cnt_q <= rsv_cnt_d;
      filled_cnt_q <= filled_cnt_d;
    end
  end

endmodule

// File: hw/link_table.sv
// Next-pointer table chaining each identifier's slots; written per reservation, read without latency
module link_table import wr_resp_bank_pkg::*; (
  input logic   clk_i,
  input logic   rst_ni,
  link_if.tbl   link
);

  addr_t next_q [Capacity];

  ////////////////////////////////////////////////////////////////////////////
  // Write port
  ////////////////////////////////////////////////////////////////////////////

  // The old head of a queue learns its successor when a new slot is reserved
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      for (int a = 0; a < Capacity; a++) begin
        next_q[a] <= '0;
      end
    end else if (link.wr_en) begin
      next_q[link.wr_addr] <= link.wr_next;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Read ports
  ////////////////////////////////////////////////////////////////////////////

  // A link is always written at least one cycle before it is followed
  assign link.fill_next = next_q[link.fill_addr];
  assign link.rel_next = next_q[link.rel_addr];

endmodule

// File: hw/slot_allocator.sv
// Occupancy tracker of the bank slots; offers the lowest free address for the next reservation
module slot_allocator import wr_resp_bank_pkg::*; (
  input  logic                clk_i,
  input  logic                rst_ni,
  input  logic                i_rsv_fire,
  input  logic [Capacity-1:0] i_release_onehot,
  output addr_t               o_free_addr,
  output logic                o_any_free
);

  logic [Capacity-1:0] occupied_q;
  logic [Capacity-1:0] occupied_d;

  // Lowest clear bit wins, scanned from the top down
  always_comb begin
    o_free_addr = '0;
    for (int a = Capacity - 1; a >= 0; a--) begin
      if (!occupied_q[a]) begin
        o_free_addr = addr_t'(a);
      end
    end
  end

  assign o_any_free = ~&occupied_q;

  // Reserved and released slots never coincide, a released slot is occupied
  always_comb begin
    occupied_d = occupied_q & ~i_release_onehot;
    if (i_rsv_fire) begin
      occupied_d[o_free_addr] = 1'b1;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      occupied_q <= '0;
    end else begin
      occupied_q <= occupied_d;
    end
  end

endmodule

// File: hw/link_if.sv
// Next-pointer table access between the queue pointers (queue side) and the table (table side)
interface link_if import wr_resp_bank_pkg::*; ();

  // Write port, one link per reservation
  logic  wr_en;
  addr_t wr_addr;
  addr_t wr_next;

  // Two combinational read ports, for the fill and release pointers
  addr_t fill_addr;
  addr_t fill_next;
  addr_t rel_addr;
  addr_t rel_next;

  modport tbl (
    input  wr_en, wr_addr, wr_next,
    input  fill_addr, rel_addr,
    output fill_next, rel_next
  );

  modport queue (
    output wr_en, wr_addr, wr_next,
    output fill_addr, rel_addr,
    input  fill_next, rel_next
  );

endinterface

// File: hw/wr_resp_bank_pkg.sv
// Sizes and word types shared by the write-response bank; import with a wildcard in module headers
package wr_resp_bank_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // Sizes
  ////////////////////////////////////////////////////////////////////////////

  // AXI identifiers handled by the bank
  localparam int unsigned NumIds = 4;
  localparam int unsigned IdWidth = 2;

  // Slots shared by all identifiers
  localparam int unsigned Capacity = 16;
  localparam int unsigned AddrWidth = 4;

  // One bit wider than an address so a count can reach Capacity
  localparam int unsigned CntWidth = 5;

  // Response payload without its identifier
  localparam int unsigned MsgWidth = 8;

  ////////////////////////////////////////////////////////////////////////////
  // Word types
  ////////////////////////////////////////////////////////////////////////////

  typedef logic [IdWidth-1:0] id_t;
  typedef logic [AddrWidth-1:0] addr_t;
  typedef logic [CntWidth-1:0] cnt_t;
  typedef logic [MsgWidth-1:0] msg_t;

endpackage
